//--- source/opl_timer_defines.svh
`ifndef OPL_TIMER_DEFINES_SVH
`define OPL_TIMER_DEFINES_SVH

// host data bus width
`define OPL_DATA_W 8

// timer preset and tick counter width
`define OPL_PRESET_W 8

// tick intervals in microseconds
`define OPL_TIMER1_TICK_US 80
`define OPL_TIMER2_TICK_US 320

// register indexes served by the timer block
`define OPL_REG_TIMER1 8'h02
`define OPL_REG_TIMER2 8'h03

// start, mask and flag reset bits
`define OPL_REG_TIMER_CTRL 8'h04

`endif

//--- source/opl_bus_pkg.sv
`include "opl_timer_defines.svh"

package opl_bus_pkg;

  // one byte on the host data bus
  typedef logic [`OPL_DATA_W-1:0] bus_data_t;

  // register index, loaded by an address write
  typedef logic [`OPL_DATA_W-1:0] reg_index_t;

  // status byte returned on a read with a0 low
  typedef struct packed {
    // bit 7, set while either flag is set
    logic       irq_any;
    // bit 6
    logic       t1_flag;
    // bit 5
    logic       t2_flag;
    // bits 4..0 always read as zero
    logic [4:0] reserved;
  } status_t;

endpackage

//--- source/opl_timer_pkg.sv
`include "opl_timer_defines.svh"

package opl_timer_pkg;

  // start value loaded into a timer on activation and after overflow
  typedef logic [`OPL_PRESET_W-1:0] preset_t;

  // tick counter, overflows after 0xff
  typedef logic [`OPL_PRESET_W-1:0] tick_count_t;

  // byte written to the timer control register
  typedef struct packed {
    // clears both flags, other fields ignored when set
    logic       flag_reset;
    logic       t1_mask;
    logic       t2_mask;
    logic [2:0] unused;
    logic       t2_start;
    logic       t1_start;
  } timer_ctrl_t;

endpackage

//--- source/host_bus_port.sv
`include "opl_timer_defines.svh"

module host_bus_port (
  input  logic                  clk,
  input  logic                  rst,
  input  opl_bus_pkg::bus_data_t din,
  input  logic                  cs_n,
  input  logic                  wr_n,
  input  logic                  a0,
  output opl_bus_pkg::bus_data_t dout,
  input  opl_bus_pkg::status_t   status,
  output logic                  preset1_we,
  output logic                  preset2_we,
  output logic                  ctrl_we,
  output opl_bus_pkg::bus_data_t wdata
);

  logic                    read;
  logic                    write;
  logic                    addr_write;
  logic                    data_write;
  opl_bus_pkg::reg_index_t index;

  // bus cycle decode
  assign read       = !cs_n && !a0;
  assign write      = !cs_n && !wr_n;
  assign addr_write = write && !a0;
  assign data_write = write && a0;

  // index register, picked up on an address write
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      index <= '0;
    end else if (addr_write) begin
      index <= din;
    end
  end

  // write strobes per timer register
  // other indexes are accepted and dropped
  assign preset1_we = data_write && (index == `OPL_REG_TIMER1);
  assign preset2_we = data_write && (index == `OPL_REG_TIMER2);
  assign ctrl_we    = data_write && (index == `OPL_REG_TIMER_CTRL);

  assign wdata = din;

  // status read, no latency
  assign dout = read ? opl_bus_pkg::bus_data_t'(status) : '0;

endmodule

//--- source/interval_timer.sv
module interval_timer #(
  parameter int tick_cycles = 80
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   active,
  input  opl_timer_pkg::preset_t preset,
  output logic                   overflow
);

  // prescaler wide enough for tick_cycles - 1
  localparam int presc_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
  localparam logic [presc_w-1:0] presc_reload = presc_w'(tick_cycles - 1);

  logic                       active_d;
  logic                       start;
  logic                       tick;
  logic [presc_w-1:0]         prescaler;
  opl_timer_pkg::tick_count_t count;

  // first cycle of a new activation
  assign start = active && !active_d;

  // prescaler wrap, one per tick_cycles clocks
  assign tick = active && !start && (prescaler == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active_d <= 1'b0;
    end else begin
      active_d <= active;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prescaler <= '0;
      count     <= '0;
      overflow  <= 1'b0;
    end else begin
      overflow <= 1'b0;
      if (start) begin
        count     <= preset;
        prescaler <= presc_reload;
      end else if (tick) begin
        prescaler <= presc_reload;
        if (count == '1) begin
          // wrap back to the preset and flag it
          count    <= preset;
          overflow <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end else if (active) begin
        prescaler <= prescaler - 1'b1;
      end
    end
  end

endmodule

//--- source/timer_status.sv
`include "opl_timer_defines.svh"

module timer_status #(
  parameter int clk_mhz = 50
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   preset1_we,
  input  logic                   preset2_we,
  input  logic                   ctrl_we,
  input  opl_bus_pkg::bus_data_t wdata,
  output opl_bus_pkg::status_t   status,
  output logic                   irq_n
);

  // clocks per tick for each timer
  localparam int t1_cycles = clk_mhz * `OPL_TIMER1_TICK_US;
  localparam int t2_cycles = clk_mhz * `OPL_TIMER2_TICK_US;

  opl_timer_pkg::timer_ctrl_t ctrl;
  opl_timer_pkg::preset_t     preset1;
  opl_timer_pkg::preset_t     preset2;
  logic                       t1_mask;
  logic                       t2_mask;
  logic                       t1_start;
  logic                       t2_start;
  logic                       t1_pulse;
  logic                       t2_pulse;
  logic                       t1_flag;
  logic                       t2_flag;
  logic                       flag_clear;
  logic                       irq_set;

  assign ctrl       = opl_timer_pkg::timer_ctrl_t'(wdata);
  assign flag_clear = ctrl_we && ctrl.flag_reset;

  // preset bytes
  always_ff @(posedge clk) begin
    if (preset1_we) begin
      preset1 <= wdata;
    end
    if (preset2_we) begin
      preset2 <= wdata;
    end
  end

  // masks and start bits, untouched by a flag reset write
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      t1_mask  <= 1'b0;
      t2_mask  <= 1'b0;
      t1_start <= 1'b0;
      t2_start <= 1'b0;
    end else if (ctrl_we && !ctrl.flag_reset) begin
      t1_mask  <= ctrl.t1_mask;
      t2_mask  <= ctrl.t2_mask;
      t1_start <= ctrl.t1_start;
      t2_start <= ctrl.t2_start;
    end
  end

  interval_timer #(
    .tick_cycles(t1_cycles)
  ) timer1_i (
    .clk     (clk),
    .rst     (rst),
    .active  (t1_start),
    .preset  (preset1),
    .overflow(t1_pulse)
  );

  interval_timer #(
    .tick_cycles(t2_cycles)
  ) timer2_i (
    .clk     (clk),
    .rst     (rst),
    .active  (t2_start),
    .preset  (preset2),
    .overflow(t2_pulse)
  );

  // overflow wins over a flag reset in the same cycle
  // masked overflows still set their flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      t1_flag <= 1'b0;
      t2_flag <= 1'b0;
    end else begin
      if (t1_pulse) begin
        t1_flag <= 1'b1;
      end else if (flag_clear) begin
        t1_flag <= 1'b0;
      end
      if (t2_pulse) begin
        t2_flag <= 1'b1;
      end else if (flag_clear) begin
        t2_flag <= 1'b0;
      end
    end
  end

  assign irq_set = (t1_pulse && !t1_mask) || (t2_pulse && !t2_mask);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_n <= 1'b1;
    end else if (irq_set) begin
      irq_n <= 1'b0;
    end else if (flag_clear) begin
      irq_n <= 1'b1;
    end
  end

  assign status.irq_any  = t1_flag | t2_flag;
  assign status.t1_flag  = t1_flag;
  assign status.t2_flag  = t2_flag;
  assign status.reserved = '0;

endmodule

//--- source/opl2_timer_top.sv
module opl2_timer_top #(
  parameter int clk_mhz = 50
) (
  input  logic                   clk,
  input  logic                   rst,
  input  opl_bus_pkg::bus_data_t din,
  output opl_bus_pkg::bus_data_t dout,
  input  logic                   cs_n,
  input  logic                   wr_n,
  input  logic                   a0,
  output logic                   irq_n
);

  opl_bus_pkg::status_t   status;
  opl_bus_pkg::bus_data_t wdata;
  logic                   preset1_we;
  logic                   preset2_we;
  logic                   ctrl_we;

  // host side, index register and status read
  host_bus_port bus_i (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .cs_n      (cs_n),
    .wr_n      (wr_n),
    .a0        (a0),
    .dout      (dout),
    .status    (status),
    .preset1_we(preset1_we),
    .preset2_we(preset2_we),
    .ctrl_we   (ctrl_we),
    .wdata     (wdata)
  );

  // both interval timers with their flags and irq
  timer_status #(
    .clk_mhz(clk_mhz)
  ) timers_i (
    .clk       (clk),
    .rst       (rst),
    .preset1_we(preset1_we),
    .preset2_we(preset2_we),
    .ctrl_we   (ctrl_we),
    .wdata     (wdata),
    .status    (status),
    .irq_n     (irq_n)
  );

endmodule

//--- testbench/opl2_timer_properties.sv
module opl2_timer_properties (
  input logic                   clk,
  input logic                   rst,
  input logic                   cs_n,
  input logic                   a0,
  input opl_bus_pkg::bus_data_t dout,
  input opl_bus_pkg::status_t   status,
  input logic                   irq_n
);

  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0;
  logic read;
  logic t1_flag;
  logic t2_flag;

  assign read    = !cs_n && !a0;
  assign t1_flag = status.t1_flag;
  assign t2_flag = status.t2_flag;

  // nothing driven back outside a status read
  idle_dout_zero: assert property (@(posedge clk) disable iff (rst)
    !read |-> dout == '0)
    else begin
      $error("dout is not zero outside a status read");
      fail_count = fail_count + 1;
    end

  // irq summary bit and reserved bits of the status byte
  status_layout: assert property (@(posedge clk) disable iff (rst)
    read |-> (dout[7] == (dout[6] | dout[5])) && (dout[4:0] == 5'b0))
    else begin
      $error("status byte read with a bad irq bit or reserved bits");
      fail_count = fail_count + 1;
    end

  // irq_n only drops together with a newly set flag
  irq_needs_new_flag: assert property (@(posedge clk) disable iff (rst)
    $fell(irq_n) |-> ($rose(t1_flag) || $rose(t2_flag)))
    else begin
      $error("irq_n went low without a new timer flag");
      fail_count = fail_count + 1;
    end

endmodule

bind opl2_timer_top opl2_timer_properties props_i (
  .clk   (clk),
  .rst   (rst),
  .cs_n  (cs_n),
  .a0    (a0),
  .dout  (dout),
  .status(status),
  .irq_n (irq_n)
);

//--- testbench/opl2_timer_tb.sv
`include "opl_timer_defines.svh"

module opl2_timer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_mhz     = 1;
  localparam int half_period = 2;
  // 80 us and 320 us ticks at 1 MHz
  localparam int t1_cycles   = 80;
  localparam int t2_cycles   = 320;
  localparam int slack       = 4;
  // bus traffic around each test
  localparam int bus_cycles  = 40;

  // expected length of each test in clocks
  localparam int test1_len = bus_cycles;
  localparam int test2_len = (256 - 'hFD) * t1_cycles + bus_cycles;
  localparam int test3_len = bus_cycles;
  localparam int test4_len = 2 * t2_cycles + slack + bus_cycles;
  localparam int test5_len = 25 * t1_cycles + 4 * bus_cycles;
  // worst case of the random presets is 0xfa
  localparam int test6_len = (256 - 'hFA) * t2_cycles + bus_cycles;
  localparam int run_len   = 10 + test1_len + test2_len + test3_len + test4_len
                           + test5_len + test6_len;
  localparam int watchdog_cycles = run_len * 12 / 10;

  logic                   clk = 1'b0;
  logic                   rst;
  opl_bus_pkg::bus_data_t din;
  opl_bus_pkg::bus_data_t dout;
  logic                   cs_n;
  logic                   wr_n;
  logic                   a0;
  logic                   irq_n;

  int    seed = 74053;
  int    cycle = 0;
  int    write_cycle = 0;
  int    errors = 0;
  int    tests_run = 0;
  int    tests_ok = 0;
  int    test_errors = 0;
  string test_name;

  opl2_timer_top #(
    .clk_mhz(clk_mhz)
  ) dut_i (
    .clk  (clk),
    .rst  (rst),
    .din  (din),
    .dout (dout),
    .cs_n (cs_n),
    .wr_n (wr_n),
    .a0   (a0),
    .irq_n(irq_n)
  );

  always #half_period clk = ~clk;

  // clock edge counter for latency measurement
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_ok++;
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d error(s)", test_name, test_errors);
    end
  endtask

  task automatic check_value(input string what, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %s %s: expected 0x%02h, actual 0x%02h", test_name, what,
               expected, actual);
      test_errors++;
      errors++;
    end
  endtask

  task automatic check_level(input string what, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("FAIL %s %s: expected %b, actual %b", test_name, what, expected, actual);
      test_errors++;
      errors++;
    end
  endtask

  task automatic check_window(input string what, input int expected, input int actual);
    assert (actual >= 0) else begin
      $display("FAIL %s %s: never seen before the wait limit ran out", test_name, what);
      test_errors++;
      errors++;
    end
    if (actual >= 0) begin
      assert (actual >= expected - slack && actual <= expected + slack) else begin
        $display("FAIL %s %s: expected %0d +/- %0d cycles, actual %0d", test_name, what,
                 expected, slack, actual);
        test_errors++;
        errors++;
      end
    end
  endtask

  // address phase then data phase
  task automatic write_reg(input logic [7:0] index, input logic [7:0] data);
    @(posedge clk);
    cs_n <= 1'b0;
    wr_n <= 1'b0;
    a0   <= 1'b0;
    din  <= index;
    @(posedge clk);
    a0  <= 1'b1;
    din <= data;
    write_cycle = cycle;
    @(posedge clk);
    cs_n <= 1'b1;
    wr_n <= 1'b1;
    din  <= '0;
  endtask

  task automatic read_status(output logic [7:0] value);
    @(posedge clk);
    cs_n <= 1'b0;
    a0   <= 1'b0;
    @(posedge clk);
    value = dout;
    cs_n <= 1'b1;
    a0   <= 1'b1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // clocks from the last data write until irq_n went low or -1 on a miss
  task automatic wait_irq(input int limit, output int elapsed);
    while (irq_n !== 1'b0 && cycle - write_cycle <= limit) begin
      @(posedge clk);
    end
    if (irq_n === 1'b0) begin
      elapsed = cycle - write_cycle - 1;
    end else begin
      elapsed = -1;
    end
  endtask

  // holds a status read and notes when each flag shows up
  task automatic watch_flags(input int limit, output int t1_seen, output int t2_seen);
    t1_seen = -1;
    t2_seen = -1;
    @(posedge clk);
    cs_n <= 1'b0;
    a0   <= 1'b0;
    while ((t1_seen < 0 || t2_seen < 0) && cycle - write_cycle <= limit) begin
      @(posedge clk);
      if (t1_seen < 0 && dout[6]) begin
        t1_seen = cycle - write_cycle - 1;
      end
      if (t2_seen < 0 && dout[5]) begin
        t2_seen = cycle - write_cycle - 1;
      end
    end
    cs_n <= 1'b1;
    a0   <= 1'b1;
  endtask

  initial begin
    #(watchdog_cycles * 2 * half_period);
    $display("timeout: run did not finish within %0d clock cycles", watchdog_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [7:0] value;
    int         elapsed;
    int         p1;
    int         p2;
    int         exp1;
    int         exp2;
    int         seen1;
    int         seen2;
    int         total;

    rst  = 1'b1;
    din  = '0;
    cs_n = 1'b1;
    wr_n = 1'b1;
    a0   = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    begin_test("reset_state");
    read_status(value);
    check_value("status", 8'h00, value);
    check_level("irq_n", 1'b1, irq_n);
    end_test();

    // timer 1 unmasked and three ticks from overflow
    begin_test("timer1_irq");
    write_reg(`OPL_REG_TIMER1, 8'hFD);
    write_reg(`OPL_REG_TIMER_CTRL, 8'h01);
    exp1 = (256 - 'hFD) * t1_cycles;
    wait_irq(exp1 + 2 * slack, elapsed);
    check_window("irq_n fall", exp1, elapsed);
    read_status(value);
    check_value("status", 8'hC0, value);
    end_test();

    begin_test("flag_reset");
    write_reg(`OPL_REG_TIMER_CTRL, 8'h80);
    read_status(value);
    check_value("status", 8'h00, value);
    check_level("irq_n", 1'b1, irq_n);
    end_test();

    // timer 2 masked while the same write stops timer 1
    begin_test("timer2_masked");
    write_reg(`OPL_REG_TIMER2, 8'hFE);
    write_reg(`OPL_REG_TIMER_CTRL, 8'h22);
    wait_cycles(2 * t2_cycles + slack);
    read_status(value);
    check_value("status", 8'hA0, value);
    check_level("irq_n", 1'b1, irq_n);
    end_test();

    begin_test("timer1_stop");
    write_reg(`OPL_REG_TIMER_CTRL, 8'h40);
    write_reg(`OPL_REG_TIMER_CTRL, 8'h80);
    write_reg(`OPL_REG_TIMER1, 8'hF0);
    write_reg(`OPL_REG_TIMER_CTRL, 8'h41);
    wait_cycles(5 * t1_cycles);
    write_reg(`OPL_REG_TIMER_CTRL, 8'h40);
    wait_cycles(20 * t1_cycles);
    read_status(value);
    check_value("status", 8'h00, value);
    check_level("irq_n", 1'b1, irq_n);
    end_test();

    begin_test("random_presets");
    p1 = 'hFA + $unsigned($random(seed)) % 6;
    p2 = 'hFA + $unsigned($random(seed)) % 6;
    exp1 = (256 - p1) * t1_cycles;
    exp2 = (256 - p2) * t2_cycles;
    write_reg(`OPL_REG_TIMER1, 8'(p1));
    write_reg(`OPL_REG_TIMER2, 8'(p2));
    write_reg(`OPL_REG_TIMER_CTRL, 8'h03);
    watch_flags(((exp1 > exp2) ? exp1 : exp2) + 2 * slack, seen1, seen2);
    check_window("timer 1 flag", exp1, seen1);
    check_window("timer 2 flag", exp2, seen2);
    check_level("irq_n", 1'b0, irq_n);
    end_test();

    total = errors + dut_i.props_i.fail_count;
    $display("%0d of %0d tests ok, %0d check errors, %0d assertion errors",
             tests_ok, tests_run, errors, dut_i.props_i.fail_count);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- opl2_timer_top.f
+incdir+source
source/opl_bus_pkg.sv
source/opl_timer_pkg.sv
source/host_bus_port.sv
source/interval_timer.sv
source/timer_status.sv
source/opl2_timer_top.sv
testbench/opl2_timer_properties.sv
testbench/opl2_timer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f opl2_timer_top.f \
  --top-module opl2_timer_tb \
  -o opl2_timer_sim

./obj_dir/opl2_timer_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
